//--- dv/rename_tb.sv
module rename_tb
    import rename_cfg_pkg::*;
    import rename_pkt_pkg::*;
();
    localparam int ways = 2;

    // One cycle of stimulus together with the responses the model expects.
    typedef struct packed {
        rename_req_t [ways-1:0] req;
        commit_t     [ways-1:0] com;
        logic                   squash;
        rename_rsp_t [ways-1:0] exp;
    } row_t;

    logic        clock;
    logic        reset;
    logic        squash;
    rename_req_t req [ways];
    commit_t     com [ways];
    rename_rsp_t rsp [ways];

    row_t        rows [$];
    string       row_names [$];
    int          watchdog_limit = 0;
    logic [15:0] lfsr_state = 16'd62;

    // Reference model state.
    prn_t        m_rat  [arch_regs];
    prn_t        m_rrat [arch_regs];
    prn_t        m_fl   [free_depth];
    int          m_head;
    int          m_tail;
    int          m_ret_head;
    int          m_count;
    commit_t     pending [$];

    rename_top #(
        .ways       (ways)
    ) i_rename_top (
        .clock      (clock),
        .reset      (reset),
        .rename_req (req),
        .commit     (com),
        .squash     (squash),
        .rename_rsp (rsp)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic rename_req_t make_req(input int a, input int b, input int d);
        rename_req_t r;
        r.op1_arn  = arn_t'(a);
        r.op2_arn  = arn_t'(b);
        r.dest_arn = arn_t'(d);
        return r;
    endfunction

    function automatic string format_rsp(input rename_rsp_t r);
        return $sformatf("op1=%0d op2=%0d dv=%0b dest=%0d",
                         r.op1_prn, r.op2_prn, r.dest_valid, r.dest_prn);
    endfunction

    task automatic model_reset();
        for (int i = 0; i < arch_regs; i++) begin
            m_rat[i]  = prn_t'(i);
            m_rrat[i] = prn_t'(i);
        end
        for (int i = 0; i < free_depth; i++) begin
            m_fl[i] = prn_t'(arch_regs + i);
        end
        m_head     = 0;
        m_tail     = 0;
        m_ret_head = 0;
        m_count    = free_depth;
        pending.delete();
    endtask

    // Commits are taken oldest first from the outstanding allocations, then
    // the bundle is renamed against the model and its state is advanced.
    task automatic add_row(input string name, input rename_req_t r0, input rename_req_t r1,
                           input int n_commit, input logic sq);
        row_t    row;
        prn_t    pushed [$];
        commit_t c;
        int      taken;
        row = '0;
        row.req[0] = r0;
        row.req[1] = r1;
        row.squash = sq;
        for (int l = 0; l < ways; l++) begin
            if (l < n_commit && pending.size() > 0) begin
                row.com[l] = pending.pop_front();
            end
        end
        for (int l = 0; l < ways; l++) begin
            if (row.com[l].valid && row.com[l].dest_arn != 0) begin
                pushed.push_back(m_rrat[row.com[l].dest_arn]);
                m_rrat[row.com[l].dest_arn] = row.com[l].prn;
            end
        end
        taken = 0;
        if (!sq) begin
            for (int l = 0; l < ways; l++) begin
                row.exp[l].op1_prn = m_rat[row.req[l].op1_arn];
                row.exp[l].op2_prn = m_rat[row.req[l].op2_arn];
                if (row.req[l].dest_arn != 0 && taken < m_count) begin
                    row.exp[l].dest_valid = 1'b1;
                    row.exp[l].dest_prn   = m_fl[(m_head + taken) % free_depth];
                    m_rat[row.req[l].dest_arn] = row.exp[l].dest_prn;
                    c.valid    = 1'b1;
                    c.dest_arn = row.req[l].dest_arn;
                    c.prn      = row.exp[l].dest_prn;
                    pending.push_back(c);
                    taken++;
                end
            end
        end
        m_head  = (m_head + taken) % free_depth;
        m_count = m_count - taken;
        foreach (pushed[p]) begin
            m_fl[m_tail] = pushed[p];
            m_tail     = (m_tail + 1) % free_depth;
            m_ret_head = (m_ret_head + 1) % free_depth;
            m_count++;
        end
        if (sq) begin
            // Every allocation still waiting to commit goes back to the list.
            m_rat   = m_rrat;
            m_head  = m_ret_head;
            m_count = m_count + pending.size();
            pending.delete();
        end
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_directed();
        add_row("reset_identity", make_req(3, 4, 5), make_req(6, 7, 8), 0, 1'b0);
        add_row("bundle_forward", make_req(1, 2, 9), make_req(9, 5, 10), 0, 1'b0);
        add_row("dest_zero_skip", make_req(9, 10, 0), make_req(8, 0, 11), 0, 1'b0);
        // Five registers are gone, so 13 full bundles leave exactly one.
        for (int i = 0; i < 13; i++) begin
            add_row($sformatf("drain_%0d", i), make_req(i + 1, i + 2, (2 * i) % 31 + 1),
                    make_req(i + 3, 9, (2 * i + 1) % 31 + 1), 0, 1'b0);
        end
        add_row("last_entry", make_req(1, 2, 20), make_req(3, 4, 21), 0, 1'b0);
        add_row("refused_keeps_map", make_req(21, 20, 0), make_req(21, 0, 0), 0, 1'b0);
        add_row("empty_list", make_req(5, 6, 7), make_req(8, 9, 10), 0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_row($sformatf("commit_free_%0d", i), make_req(1, 2, 0), make_req(3, 4, 0),
                    2, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            add_row($sformatf("recycle_%0d", i), make_req(5, 8, 12 + i), make_req(12 + i, 9, 22),
                    0, 1'b0);
        end
        add_row("commit_and_rename_0", make_req(22, 1, 23), make_req(23, 2, 24), 2, 1'b0);
        add_row("commit_and_rename_1", make_req(24, 3, 25), make_req(25, 4, 26), 2, 1'b0);
        add_row("spec_rename_0", make_req(5, 8, 5), make_req(5, 9, 8), 0, 1'b0);
        add_row("spec_rename_1", make_req(8, 1, 9), make_req(9, 2, 1), 0, 1'b0);
        add_row("squash_commit", make_req(5, 8, 12), make_req(9, 1, 13), 1, 1'b1);
        // Register 6 is the destination retired by the commit in the squash cycle.
        add_row("after_squash_0", make_req(5, 8, 14), make_req(9, 6, 15), 0, 1'b0);
        add_row("after_squash_1", make_req(14, 15, 16), make_req(16, 21, 17), 0, 1'b0);
    endtask

    task automatic build_random(input int n_rows);
        int   f [7];
        logic sq;
        for (int r = 0; r < n_rows; r++) begin
            for (int j = 0; j < 6; j++) begin
                f[j] = take_bits(arn_w);
            end
            f[6] = take_bits(2);
            sq   = (take_bits(4) == 0);
            add_row($sformatf("random_%0d", r), make_req(f[0], f[1], f[2]),
                    make_req(f[3], f[4], f[5]), f[6], sq);
        end
    endtask

    task automatic check_rsp(input string name, input int lane, input rename_rsp_t expected,
                             input rename_rsp_t actual);
        if (actual !== expected) begin
            $display("ERROR %s lane %0d: expected %s, actual %s", name, lane,
                     format_rsp(expected), format_rsp(actual));
            $display("RESULT: FAIL");
            $fatal(1, "Rename response mismatch");
        end
    endtask

    initial begin
        wait (watchdog_limit > 0);
        #(watchdog_limit);
        $display("The run timed out after %0d time units without finishing the table.",
                 watchdog_limit);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset  = 1'b1;
        squash = 1'b0;
        for (int l = 0; l < ways; l++) begin
            req[l] = '0;
            com[l] = '0;
        end
        model_reset();
        build_directed();
        build_random(240);
        watchdog_limit = (rows.size() + 2) * 4 + 100;

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int r = 0; r < rows.size(); r++) begin
            for (int l = 0; l < ways; l++) begin
                req[l] = rows[r].req[l];
                com[l] = rows[r].com[l];
            end
            squash = rows[r].squash;
            // Responses are combinational, so sample one unit before the edge.
            #2;
            for (int l = 0; l < ways; l++) begin
                check_rsp(row_names[r], l, rows[r].exp[l], rsp[l]);
            end
            @(posedge clock);
            #1;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- logic/rat.sv
module rat
    import rename_cfg_pkg::*;
    import rename_pkt_pkg::*;
#(
    parameter int ways = 2
) (
    input  logic            clock,
    input  logic            reset,
    input  rename_req_t     rename_req    [ways],
    input  free_pkt_t       pop_pkt       [ways],
    input  prn_t            committed_map [arch_regs],
    input  logic            squash,
    output rename_rsp_t     rename_rsp    [ways],
    output logic [ways-1:0] pop_en
);
    prn_t rat_table      [arch_regs];
    prn_t next_rat_table [arch_regs];

    // Requests for a fresh register depend only on the bundle itself, so this
    // stays separate from the table walk that consumes the pop results.
    always_comb begin
        for (int i = 0; i < ways; i++) begin
            pop_en[i] = (rename_req[i].dest_arn != '0) && !squash;
        end
    end

    // Lanes are walked in order against a running copy of the table, so a
    // later lane sees the destinations renamed by earlier lanes this cycle.
    always_comb begin
        next_rat_table = rat_table;
        for (int i = 0; i < ways; i++) begin
            rename_rsp[i] = '0;
        end

        if (squash) begin
            next_rat_table = committed_map;
        end else begin
            for (int i = 0; i < ways; i++) begin
                rename_rsp[i].op1_prn = next_rat_table[rename_req[i].op1_arn];
                rename_rsp[i].op2_prn = next_rat_table[rename_req[i].op2_arn];

                // A refused lane leaves its destination mapping untouched.
                if (pop_en[i] && pop_pkt[i].valid) begin
                    next_rat_table[rename_req[i].dest_arn] = pop_pkt[i].prn;
                    rename_rsp[i].dest_valid = 1'b1;
                    rename_rsp[i].dest_prn   = pop_pkt[i].prn;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                rat_table[i] <= prn_t'(i);
            end
        end else begin
            rat_table <= next_rat_table;
        end
    end

endmodule

//--- logic/rat_free_list.sv
module rat_free_list
    import rename_cfg_pkg::*;
    import rename_pkt_pkg::*;
#(
    parameter int ways = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [ways-1:0]  pop_en,
    input  free_pkt_t        push_pkt [ways],
    input  logic             squash,
    output free_pkt_t        pop_pkt  [ways]
);
    prn_t      fl_mem [free_depth];
    fl_ptr_t   head;
    fl_ptr_t   tail;
    fl_ptr_t   ret_head;
    fl_count_t count;

    fl_count_t n_pop;
    fl_count_t n_push;
    fl_ptr_t   push_addr [ways];

    fl_ptr_t   next_head;
    fl_ptr_t   next_tail;
    fl_ptr_t   next_ret_head;
    fl_count_t next_count;

    // Enabled lanes are served in lane order from head. Once the list runs
    // dry every later lane is refused and nothing is consumed for it.
    always_comb begin
        fl_count_t k;
        k = '0;
        n_pop = '0;
        for (int i = 0; i < ways; i++) begin
            pop_pkt[i] = '0;
            if (pop_en[i]) begin
                if (k < count) begin
                    pop_pkt[i].valid = 1'b1;
                    pop_pkt[i].prn   = fl_mem[fl_ptr_t'(head + k)];
                    n_pop            = n_pop + 1'b1;
                end
                k = k + 1'b1;
            end
        end
    end

    // Valid pushes pack densely at tail in lane order.
    always_comb begin
        n_push = '0;
        for (int i = 0; i < ways; i++) begin
            push_addr[i] = fl_ptr_t'(tail + n_push);
            if (push_pkt[i].valid) begin
                n_push = n_push + 1'b1;
            end
        end
    end

    always_comb begin
        next_tail     = fl_ptr_t'(tail + n_push);
        next_ret_head = fl_ptr_t'(ret_head + n_push);
        if (squash) begin
            // Every allocation past the retirement head was speculative.
            next_head = next_ret_head;
            if (next_tail == next_head) begin
                next_count = fl_count_t'(free_depth);
            end else begin
                next_count = fl_count_t'(fl_ptr_t'(next_tail - next_head));
            end
        end else begin
            next_head  = fl_ptr_t'(head + n_pop);
            next_count = count - n_pop + n_push;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < free_depth; i++) begin
                fl_mem[i] <= prn_t'(arch_regs + i);
            end
            head     <= '0;
            tail     <= '0;
            ret_head <= '0;
            count    <= fl_count_t'(free_depth);
        end else begin
            for (int i = 0; i < ways; i++) begin
                if (push_pkt[i].valid) begin
                    fl_mem[push_addr[i]] <= push_pkt[i].prn;
                end
            end
            head     <= next_head;
            tail     <= next_tail;
            ret_head <= next_ret_head;
            count    <= next_count;
        end
    end

endmodule

//--- logic/rename_cfg_pkg.sv
package rename_cfg_pkg;

    // Architectural register space. Register 0 is hardwired and never renamed.
    localparam int arch_regs = 32;

    // Unified physical register file shared by committed and speculative state.
    localparam int phys_regs = 64;

    // Registers not held by the committed map live in the free list.
    localparam int free_depth = phys_regs - arch_regs;

    localparam int arn_w = $clog2(arch_regs);
    localparam int prn_w = $clog2(phys_regs);

    // The pointer is exactly log2 of the depth so that it wraps on its own.
    localparam int fl_ptr_w = $clog2(free_depth);

    // One extra bit so a full list (free_depth entries) can be told apart from empty.
    localparam int fl_count_w = fl_ptr_w + 1;

    // Architectural register number.
    typedef logic [arn_w-1:0] arn_t;

    // Physical register number.
    typedef logic [prn_w-1:0] prn_t;

    // Index into the circular free list.
    typedef logic [fl_ptr_w-1:0] fl_ptr_t;

    // Free list occupancy, 0 through free_depth.
    typedef logic [fl_count_w-1:0] fl_count_t;

endpackage

//--- logic/rename_pkt_pkg.sv
package rename_pkt_pkg;

    // One instruction entering rename.
    // A dest_arn of 0 means the instruction writes no register.
    typedef struct packed {
        rename_cfg_pkg::arn_t op1_arn;
        rename_cfg_pkg::arn_t op2_arn;
        rename_cfg_pkg::arn_t dest_arn;
    } rename_req_t;

    // Renamed operands for one lane.
    // dest_prn is zero whenever dest_valid is low.
    typedef struct packed {
        rename_cfg_pkg::prn_t op1_prn;
        rename_cfg_pkg::prn_t op2_prn;
        logic                 dest_valid;
        rename_cfg_pkg::prn_t dest_prn;
    } rename_rsp_t;

    // One retiring instruction.
    // prn is the physical register this instruction was given at rename.
    typedef struct packed {
        logic                 valid;
        rename_cfg_pkg::arn_t dest_arn;
        rename_cfg_pkg::prn_t prn;
    } commit_t;

    // A physical register moving into or out of the free list.
    // The same shape serves pop results and pushes.
    typedef struct packed {
        logic                 valid;
        rename_cfg_pkg::prn_t prn;
    } free_pkt_t;

endpackage

//--- logic/rename_top.sv
module rename_top
    import rename_cfg_pkg::*;
    import rename_pkt_pkg::*;
#(
    parameter int ways = 2
) (
    input  logic        clock,
    input  logic        reset,
    input  rename_req_t rename_req [ways],
    input  commit_t     commit     [ways],
    input  logic        squash,
    output rename_rsp_t rename_rsp [ways]
);
    logic [ways-1:0] pop_en;
    free_pkt_t       pop_pkt       [ways];
    free_pkt_t       push_pkt      [ways];
    prn_t            committed_map [arch_regs];

    // Speculative map. Renames the incoming bundle and asks the free list
    // for one register per lane that writes a destination.
    rat #(
        .ways          (ways)
    ) i_rat (
        .clock         (clock),
        .reset         (reset),
        .rename_req    (rename_req),
        .pop_pkt       (pop_pkt),
        .committed_map (committed_map),
        .squash        (squash),
        .rename_rsp    (rename_rsp),
        .pop_en        (pop_en)
    );

    // Free physical registers. Pops go to the rename table, pushes come
    // from retirement, and squash rewinds head to the retirement head.
    rat_free_list #(
        .ways     (ways)
    ) i_rat_free_list (
        .clock    (clock),
        .reset    (reset),
        .pop_en   (pop_en),
        .push_pkt (push_pkt),
        .squash   (squash),
        .pop_pkt  (pop_pkt)
    );

    // Committed map. Returns displaced registers to the free list and
    // provides the restore image for a squash.
    rrat #(
        .ways          (ways)
    ) i_rrat (
        .clock         (clock),
        .reset         (reset),
        .commit        (commit),
        .push_pkt      (push_pkt),
        .committed_map (committed_map)
    );

endmodule

//--- logic/rrat.sv
module rrat
    import rename_cfg_pkg::*;
    import rename_pkt_pkg::*;
#(
    parameter int ways = 2
) (
    input  logic      clock,
    input  logic      reset,
    input  commit_t   commit        [ways],
    output free_pkt_t push_pkt      [ways],
    output prn_t      committed_map [arch_regs]
);
    prn_t rrat_table      [arch_regs];
    prn_t next_rrat_table [arch_regs];

    // Commits retire in lane order. Each one displaces whatever the
    // committed map held for its destination, including a mapping installed
    // by an earlier lane of the same bundle, and that register is freed.
    always_comb begin
        next_rrat_table = rrat_table;
        for (int i = 0; i < ways; i++) begin
            push_pkt[i] = '0;
            if (commit[i].valid && (commit[i].dest_arn != '0)) begin
                push_pkt[i].valid = 1'b1;
                push_pkt[i].prn   = next_rrat_table[commit[i].dest_arn];
                next_rrat_table[commit[i].dest_arn] = commit[i].prn;
            end
        end
    end

    // The rename table restores from the next-state copy, so a squash in the
    // same cycle as a commit already sees that commit.
    assign committed_map = next_rrat_table;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                rrat_table[i] <= prn_t'(i);
            end
        end else begin
            rrat_table <= next_rrat_table;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compiles the rename testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module rename_tb -Mdir obj_dir \
    && ./obj_dir/Vrename_tb | tee /dev/stderr | grep -qx "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb.f
logic/rename_cfg_pkg.sv
logic/rename_pkt_pkg.sv
logic/rat_free_list.sv
logic/rat.sv
logic/rrat.sv
logic/rename_top.sv
dv/rename_tb.sv
